/* common/ts_stream_pkg.sv */
package ts_stream_pkg;

  // Bit positions inside the stream header words
  localparam int PORT_LSB = 0;
  localparam int PID_LSB  = 8;

  localparam int PORT_BITS = 9;
  localparam int PID_BITS  = 13;
  localparam int RUN_BITS  = 8;

  // Run length that forces an event even when the PID repeats
  localparam logic [RUN_BITS-1:0] RUN_MAX = '1;

  typedef logic [31:0] stream_word_t;

  typedef struct packed {
    logic [PORT_BITS-1:0] port;
    logic [PID_BITS-1:0]  pid;
  } pid_key_t;

  typedef struct packed {
    logic [1:0]          zero;
    pid_key_t            key;
    logic [RUN_BITS-1:0] run;
  } pid_event_fields_t;

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } pid_event_halves_t;

  // One event word, built by field and read by the host in two halves
  typedef union packed {
    pid_event_fields_t fields;
    pid_event_halves_t halves;
  } pid_event_u;

endpackage

/* common/ts_csr_pkg.sv */
package ts_csr_pkg;

  localparam int AV_ADDR_BITS = 12;
  localparam int AV_DATA_BITS = 16;

  typedef logic [AV_DATA_BITS-1:0] av_data_t;

  // Register window is eight words above the base address
  localparam int REG_OFF_BITS = 3;

  localparam logic [REG_OFF_BITS-1:0] REG_EVT_LO    = 3'd0;
  localparam logic [REG_OFF_BITS-1:0] REG_EVT_HI    = 3'd1;
  localparam logic [REG_OFF_BITS-1:0] REG_EVT_COUNT = 3'd2;
  localparam logic [REG_OFF_BITS-1:0] REG_SEL_PORT  = 3'd3;
  localparam logic [REG_OFF_BITS-1:0] REG_TIMER_LO  = 3'd4;
  localparam logic [REG_OFF_BITS-1:0] REG_RATE_PORT = 3'd5;
  localparam logic [REG_OFF_BITS-1:0] REG_RATE      = 3'd6;
  localparam logic [REG_OFF_BITS-1:0] REG_TIMER_HI  = 3'd7;

endpackage

/* common/evt_read_if.sv */
interface evt_read_if #(
  parameter int FIFO_DEPTH = 1024
);

  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

  // Show-ahead read side, head valid while empty is low
  logic                      pop;
  ts_stream_pkg::pid_event_u head;
  logic [CNT_BITS-1:0]       count;
  logic                      empty;

  modport fifo (input pop, output head, count, empty);

  modport host (output pop, input head, count, empty);

endinterface

/* csr/ms_timer.sv */
module ms_timer #(
  parameter int MS_DIVIDE = 100
) (
  input  logic        avalon_clk,
  input  logic        avalon_rst,
  output logic [27:0] ms_count
);

  localparam int DIV_BITS = $clog2(MS_DIVIDE + 1);
  localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(MS_DIVIDE - 1);

  logic [DIV_BITS-1:0] prescale;

  // Prescaler wraps once per millisecond, counter wraps at 2^28
  always_ff @(posedge avalon_clk or posedge avalon_rst) begin
    if (avalon_rst) begin
      prescale <= '0;
      ms_count <= '0;
    end else if (prescale == DIV_LAST) begin
      prescale <= '0;
      ms_count <= ms_count + 28'd1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

endmodule

/* csr/ts_csr_decode.sv */
module ts_csr_decode #(
  parameter logic [ts_csr_pkg::AV_ADDR_BITS-1:0] BASE_ADDR = 12'h320,
  parameter int N_PORTS = 512
) (
  input  logic                                  avalon_clk,
  input  logic                                  avalon_rst,
  input  logic [ts_csr_pkg::AV_ADDR_BITS-1:0]   avalon_address,
  input  logic                                  avalon_read,
  input  logic                                  avalon_write,
  input  ts_csr_pkg::av_data_t                  avalon_writedata,
  output ts_csr_pkg::av_data_t                  avalon_readdata,
  input  ts_csr_pkg::av_data_t                  rate_value,
  input  logic [27:0]                           ms_count,
  output logic [ts_stream_pkg::PORT_BITS-1:0]   sel_port,
  output logic                                  sel_strobe,
  output logic [$clog2(N_PORTS)-1:0]            rate_port,
  output logic                                  rate_clear,
  evt_read_if.host                              evt
);

  localparam int RP_BITS = $clog2(N_PORTS);

  logic [ts_csr_pkg::AV_ADDR_BITS-1:0] rel_addr;
  logic [ts_csr_pkg::REG_OFF_BITS-1:0] reg_off;
  logic                                in_window;
  logic                                rd_hit;
  logic                                wr_hit;
  ts_csr_pkg::av_data_t                rd_mux;
  ts_csr_pkg::av_data_t                evt_hi_q;
  logic [11:0]                         timer_hi_q;

  // ----------------------------------------------------------------------
  // Address window
  // ----------------------------------------------------------------------
  assign rel_addr  = avalon_address - BASE_ADDR;
  assign reg_off   = rel_addr[ts_csr_pkg::REG_OFF_BITS-1:0];
  assign in_window = (avalon_address >= BASE_ADDR) &&
                     (rel_addr[ts_csr_pkg::AV_ADDR_BITS-1:ts_csr_pkg::REG_OFF_BITS] == '0);
  assign rd_hit    = avalon_read && in_window;
  assign wr_hit    = avalon_write && in_window;

  // Pop in the same cycle as the low-half read, head moves on next edge
  assign evt.pop = rd_hit && (reg_off == ts_csr_pkg::REG_EVT_LO) && !evt.empty;

  // ----------------------------------------------------------------------
  // Read data mux
  // ----------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    case (reg_off)
      ts_csr_pkg::REG_EVT_LO: begin
        if (!evt.empty) begin
          rd_mux = evt.head.halves.lo;
        end
      end
      ts_csr_pkg::REG_EVT_HI:    rd_mux = evt_hi_q;
      ts_csr_pkg::REG_EVT_COUNT: rd_mux = ts_csr_pkg::av_data_t'(evt.count);
      ts_csr_pkg::REG_SEL_PORT:  rd_mux = ts_csr_pkg::av_data_t'(sel_port);
      ts_csr_pkg::REG_TIMER_LO:  rd_mux = ms_count[15:0];
      ts_csr_pkg::REG_RATE_PORT: rd_mux = ts_csr_pkg::av_data_t'(rate_port);
      ts_csr_pkg::REG_RATE:      rd_mux = rate_value;
      ts_csr_pkg::REG_TIMER_HI:  rd_mux = {4'h0, timer_hi_q};
      default:                   rd_mux = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Registered readback, hi-half latches and strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge avalon_clk or posedge avalon_rst) begin
    if (avalon_rst) begin
      avalon_readdata <= '0;
      evt_hi_q        <= '0;
      timer_hi_q      <= '0;
      sel_port        <= '0;
      sel_strobe      <= 1'b0;
      rate_port       <= '0;
      rate_clear      <= 1'b0;
    end else begin
      sel_strobe <= 1'b0;
      rate_clear <= 1'b0;
      if (rd_hit) begin
        avalon_readdata <= rd_mux;
        // Upper halves frozen by the low-half read
        if (reg_off == ts_csr_pkg::REG_EVT_LO) begin
          evt_hi_q <= evt.empty ? '0 : evt.head.halves.hi;
        end
        if (reg_off == ts_csr_pkg::REG_TIMER_LO) begin
          timer_hi_q <= ms_count[27:16];
        end
      end
      if (wr_hit) begin
        case (reg_off)
          ts_csr_pkg::REG_SEL_PORT: begin
            sel_port   <= avalon_writedata[ts_stream_pkg::PORT_BITS-1:0];
            sel_strobe <= 1'b1;
          end
          ts_csr_pkg::REG_RATE_PORT: rate_port  <= avalon_writedata[RP_BITS-1:0];
          ts_csr_pkg::REG_RATE:      rate_clear <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Host never overlaps a read and a write
  a_no_rd_wr: assert property (@(posedge avalon_clk) disable iff (avalon_rst)
    !(avalon_read && avalon_write));

endmodule

/* tracker/pid_run_tracker.sv */
module pid_run_tracker (
  input  logic                                avalon_clk,
  input  logic                                avalon_rst,
  input  logic                                stream_valid,
  input  logic                                stream_start,
  input  ts_stream_pkg::stream_word_t         stream_data,
  input  logic [ts_stream_pkg::PORT_BITS-1:0] sel_port,
  input  logic                                sel_strobe,
  input  logic                                evt_full,
  output logic                                evt_push,
  output ts_stream_pkg::pid_event_u           evt_word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PID,
    ST_CHECK
  } state_t;

  typedef logic [ts_stream_pkg::RUN_BITS-1:0] run_t;

  state_t                                state;
  logic [ts_stream_pkg::PORT_BITS-1:0]   port_q;
  ts_stream_pkg::pid_key_t               new_key;
  ts_stream_pkg::pid_key_t               cur_key;
  ts_stream_pkg::pid_key_t               prev_key;
  logic                                  cur_valid;
  logic                                  prev_valid;
  logic [ts_stream_pkg::RUN_BITS-1:0]    run_count;
  logic                                  start_ok;
  logic                                  key_take;
  logic                                  run_end;

  // A push still in flight may be the one that fills the FIFO
  assign start_ok = stream_valid && stream_start && !evt_full && !evt_push;
  assign key_take = (state == ST_PID) && stream_valid && (port_q == sel_port);
  assign new_key  = '{port: port_q,
                      pid:  stream_data[ts_stream_pkg::PID_LSB +: ts_stream_pkg::PID_BITS]};
  assign run_end  = (prev_valid && (cur_key != prev_key)) ||
                    (run_count == ts_stream_pkg::RUN_MAX);

  // ----------------------------------------------------------------------
  // Header parser and run-length control
  // ----------------------------------------------------------------------
  always_ff @(posedge avalon_clk or posedge avalon_rst) begin
    if (avalon_rst) begin
      state      <= ST_IDLE;
      cur_valid  <= 1'b0;
      prev_valid <= 1'b0;
      run_count  <= '0;
      evt_push   <= 1'b0;
    end else begin
      evt_push <= 1'b0;
      if (sel_strobe) begin
        // New port selected, forget the current run
        state      <= ST_IDLE;
        cur_valid  <= 1'b0;
        prev_valid <= 1'b0;
        run_count  <= '0;
      end else begin
        case (state)
          ST_IDLE: begin
            if (start_ok) begin
              state <= ST_PID;
            end
          end
          ST_PID: begin
            if (key_take) begin
              cur_valid  <= 1'b1;
              prev_valid <= cur_valid;
              state      <= ST_CHECK;
            end else if (stream_valid) begin
              state <= ST_IDLE;
            end
          end
          ST_CHECK: begin
            state <= ST_IDLE;
            if (run_end) begin
              evt_push  <= 1'b1;
              run_count <= run_t'(1);
            end else begin
              run_count <= run_count + 1'b1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Payload, only meaningful alongside the control above
  always_ff @(posedge avalon_clk) begin
    if ((state == ST_IDLE) && start_ok) begin
      port_q <= stream_data[ts_stream_pkg::PORT_LSB +: ts_stream_pkg::PORT_BITS];
    end
    if (key_take) begin
      prev_key <= cur_key;
      cur_key  <= new_key;
    end
    if (state == ST_CHECK) begin
      evt_word.fields <= '{zero: 2'b00, key: prev_key, run: run_count};
    end
  end

  a_no_push_full: assert property (@(posedge avalon_clk) disable iff (avalon_rst)
    evt_push |-> !evt_full);

endmodule

/* tracker/pid_event_fifo.sv */
module pid_event_fifo #(
  parameter int FIFO_DEPTH = 1024
) (
  input  logic                      avalon_clk,
  input  logic                      avalon_rst,
  input  logic                      flush,
  input  logic                      evt_push,
  input  ts_stream_pkg::pid_event_u evt_word,
  output logic                      evt_full,
  evt_read_if.fifo                  rd
);

  localparam int PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(FIFO_DEPTH - 1);

  ts_stream_pkg::pid_event_u mem [FIFO_DEPTH];
  logic [PTR_BITS-1:0]       wr_ptr;
  logic [PTR_BITS-1:0]       rd_ptr;
  logic [CNT_BITS-1:0]       fill;
  logic                      empty_w;
  logic                      do_push;
  logic                      do_pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_w  = (fill == '0);
  assign evt_full = (fill == CNT_BITS'(FIFO_DEPTH));
  assign do_push  = evt_push && !evt_full;
  assign do_pop   = rd.pop && !empty_w;

  // Show-ahead head straight from storage
  assign rd.head  = mem[rd_ptr];
  assign rd.count = fill;
  assign rd.empty = empty_w;

  always_ff @(posedge avalon_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= evt_word;
    end
  end

  always_ff @(posedge avalon_clk or posedge avalon_rst) begin
    if (avalon_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
    end
  end

  a_fill_bound: assert property (@(posedge avalon_clk) disable iff (avalon_rst)
    fill <= CNT_BITS'(FIFO_DEPTH));

endmodule

/* logic/port_rate_table.sv */
module port_rate_table #(
  parameter int N_PORTS = 512
) (
  input  logic                        avalon_clk,
  input  logic                        avalon_rst,
  input  logic                        stream_valid,
  input  logic                        stream_start,
  input  ts_stream_pkg::stream_word_t stream_data,
  input  logic [$clog2(N_PORTS)-1:0]  rate_port,
  input  logic                        rate_clear,
  output ts_csr_pkg::av_data_t        rate_value
);

  localparam int IDX_BITS = $clog2(N_PORTS);
  localparam logic [IDX_BITS-1:0] IDX_LAST = IDX_BITS'(N_PORTS - 1);

  ts_csr_pkg::av_data_t cnt_mem [N_PORTS];
  logic                 init_busy;
  logic [IDX_BITS-1:0]  init_idx;
  logic                 s1_valid;
  logic                 s2_valid;
  logic [IDX_BITS-1:0]  s1_port;
  logic [IDX_BITS-1:0]  s2_port;
  ts_csr_pkg::av_data_t s2_count;
  logic                 clr_hits_s1;
  logic                 clr_hits_s2;

  assign rate_value  = cnt_mem[rate_port];
  assign clr_hits_s1 = rate_clear && (rate_port == s1_port);
  assign clr_hits_s2 = rate_clear && (rate_port == s2_port);

  // ----------------------------------------------------------------------
  // Init sweep and pipeline valids
  // ----------------------------------------------------------------------
  always_ff @(posedge avalon_clk or posedge avalon_rst) begin
    if (avalon_rst) begin
      init_busy <= 1'b1;
      init_idx  <= '0;
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
    end else begin
      if (init_busy) begin
        init_idx <= init_idx + 1'b1;
        if (init_idx == IDX_LAST) begin
          init_busy <= 1'b0;
        end
      end
      // Starts during the sweep are dropped
      s1_valid <= !init_busy && stream_valid && stream_start;
      s2_valid <= s1_valid;
    end
  end

  // ----------------------------------------------------------------------
  // Read, add, write
  // ----------------------------------------------------------------------
  always_ff @(posedge avalon_clk) begin
    s1_port  <= stream_data[ts_stream_pkg::PORT_LSB +: IDX_BITS];
    s2_port  <= s1_port;
    s2_count <= clr_hits_s1 ? '0 : cnt_mem[s1_port];
    if (init_busy) begin
      cnt_mem[init_idx] <= '0;
    end else begin
      // Host clear wins over an increment to the same entry
      if (s2_valid && !clr_hits_s2) begin
        cnt_mem[s2_port] <= s2_count + 1'b1;
      end
      if (rate_clear) begin
        cnt_mem[rate_port] <= '0;
      end
    end
  end

endmodule

/* logic/ts_input_status.sv */
module ts_input_status #(
  parameter logic [ts_csr_pkg::AV_ADDR_BITS-1:0] BASE_ADDR = 12'h320,
  parameter int N_PORTS    = 512,
  parameter int FIFO_DEPTH = 1024,
  parameter int MS_DIVIDE  = 100
) (
  input  logic                                avalon_clk,
  input  logic                                avalon_rst,
  input  logic                                stream_valid,
  input  logic                                stream_start,
  input  ts_stream_pkg::stream_word_t         stream_data,
  input  logic [ts_csr_pkg::AV_ADDR_BITS-1:0] avalon_address,
  input  logic                                avalon_read,
  input  logic                                avalon_write,
  input  ts_csr_pkg::av_data_t                avalon_writedata,
  output ts_csr_pkg::av_data_t                avalon_readdata
);

  localparam int RP_BITS = $clog2(N_PORTS);

  logic [ts_stream_pkg::PORT_BITS-1:0] sel_port;
  logic                                sel_strobe;
  logic [RP_BITS-1:0]                  rate_port;
  logic                                rate_clear;
  ts_csr_pkg::av_data_t                rate_value;
  logic [27:0]                         ms_count;
  logic                                evt_push;
  ts_stream_pkg::pid_event_u           evt_word;
  logic                                evt_full;

  evt_read_if #(.FIFO_DEPTH(FIFO_DEPTH)) evt_rd ();

  ts_csr_decode #(.BASE_ADDR(BASE_ADDR), .N_PORTS(N_PORTS)) u_decode (
    .avalon_clk, .avalon_rst, .avalon_address, .avalon_read, .avalon_write,
    .avalon_writedata, .avalon_readdata, .rate_value, .ms_count,
    .sel_port, .sel_strobe, .rate_port, .rate_clear, .evt(evt_rd)
  );

  ms_timer #(.MS_DIVIDE(MS_DIVIDE)) u_timer (.avalon_clk, .avalon_rst, .ms_count);

  pid_run_tracker u_tracker (
    .avalon_clk, .avalon_rst, .stream_valid, .stream_start, .stream_data,
    .sel_port, .sel_strobe, .evt_full, .evt_push, .evt_word
  );

  // Selecting a new port also discards pending events
  pid_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .avalon_clk, .avalon_rst, .flush(sel_strobe), .evt_push, .evt_word,
    .evt_full, .rd(evt_rd)
  );

  port_rate_table #(.N_PORTS(N_PORTS)) u_rate (
    .avalon_clk, .avalon_rst, .stream_valid, .stream_start, .stream_data,
    .rate_port, .rate_clear, .rate_value
  );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic avalon_clk,
  output logic avalon_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    avalon_clk = 1'b0;
    forever #(PERIOD_NS / 2) avalon_clk = ~avalon_clk;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    avalon_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge avalon_clk);
    @(negedge avalon_clk);
    avalon_rst = 1'b0;
  end

endmodule

/* tests/tb_ts_input_status.sv */
module tb_ts_input_status;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [ts_csr_pkg::AV_ADDR_BITS-1:0] BASE_ADDR = 12'h320;
  localparam int N_PORTS    = 512;
  localparam int FIFO_DEPTH = 1024;
  localparam int MS_DIVIDE  = 10;
  localparam int PKT_CYCLES = 4;
  localparam int RATE_PKTS  = 48;
  localparam int SAT_PKTS   = 300;
  localparam int TIMER_K    = 20;
  localparam int POLL_LIMIT = 32;
  // Sweep, all packet traffic and the timer wait, doubled, plus register reads
  localparam int WATCHDOG_CYCLES =
    2 * (N_PORTS + (RATE_PKTS + SAT_PKTS + 32) * PKT_CYCLES + TIMER_K * MS_DIVIDE) + 1000;

  typedef logic [ts_stream_pkg::PORT_BITS-1:0] port_t;
  typedef logic [ts_stream_pkg::PID_BITS-1:0]  pid_t;
  typedef logic [ts_csr_pkg::REG_OFF_BITS-1:0] off_t;

  logic                                avalon_clk;
  logic                                avalon_rst;
  logic                                stream_valid;
  logic                                stream_start;
  ts_stream_pkg::stream_word_t         stream_data;
  logic [ts_csr_pkg::AV_ADDR_BITS-1:0] avalon_address;
  logic                                avalon_read;
  logic                                avalon_write;
  ts_csr_pkg::av_data_t                avalon_writedata;
  ts_csr_pkg::av_data_t                avalon_readdata;

  int          errors;
  int          checks;
  logic [31:0] lcg_state;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk (.avalon_clk, .avalon_rst);

  ts_input_status #(
    .BASE_ADDR(BASE_ADDR), .N_PORTS(N_PORTS), .FIFO_DEPTH(FIFO_DEPTH), .MS_DIVIDE(MS_DIVIDE)
  ) UUT (
    .avalon_clk, .avalon_rst, .stream_valid, .stream_start, .stream_data,
    .avalon_address, .avalon_read, .avalon_write, .avalon_writedata, .avalon_readdata
  );

  // ----------------------------------------------------------------------
  // Random numbers, bus access and stream packets
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic port_t random_port();
    logic [31:0] r;
    r = next_random();
    return r[24:16];
  endfunction

  function automatic pid_t random_pid();
    logic [31:0] r;
    r = next_random();
    return r[28:16];
  endfunction

  function automatic ts_stream_pkg::pid_event_u make_event(input port_t port, input pid_t pid,
                                                          input logic [7:0] run);
    ts_stream_pkg::pid_event_u ev;
    ev.fields.zero     = 2'b00;
    ev.fields.key.port = port;
    ev.fields.key.pid  = pid;
    ev.fields.run      = run;
    return ev;
  endfunction

  task automatic av_write(input off_t off, input ts_csr_pkg::av_data_t data);
    avalon_address   = BASE_ADDR + ts_csr_pkg::AV_ADDR_BITS'(off);
    avalon_writedata = data;
    avalon_write     = 1'b1;
    @(negedge avalon_clk);
    avalon_write = 1'b0;
  endtask

  // Readdata is registered, so it is taken one cycle after the read
  task automatic av_read(input off_t off, output ts_csr_pkg::av_data_t data);
    avalon_address = BASE_ADDR + ts_csr_pkg::AV_ADDR_BITS'(off);
    avalon_read    = 1'b1;
    @(negedge avalon_clk);
    avalon_read = 1'b0;
    data        = avalon_readdata;
  endtask

  // Flush and history clear land one cycle after the write
  task automatic select_port(input port_t port);
    av_write(ts_csr_pkg::REG_SEL_PORT, ts_csr_pkg::av_data_t'(port));
    @(negedge avalon_clk);
  endtask

  task automatic send_packet(input port_t port, input pid_t pid);
    stream_valid = 1'b1;
    stream_start = 1'b1;
    stream_data  = 32'(port) << ts_stream_pkg::PORT_LSB;
    @(negedge avalon_clk);
    stream_start = 1'b0;
    stream_data  = 32'(pid) << ts_stream_pkg::PID_LSB;
    @(negedge avalon_clk);
    stream_valid = 1'b0;
    stream_data  = '0;
    repeat (PKT_CYCLES - 2) @(negedge avalon_clk);
  endtask

  task automatic read_rate(input port_t port, output ts_csr_pkg::av_data_t value);
    av_write(ts_csr_pkg::REG_RATE_PORT, ts_csr_pkg::av_data_t'(port));
    av_read(ts_csr_pkg::REG_RATE, value);
  endtask

  task automatic read_event(output ts_stream_pkg::pid_event_u ev);
    ts_csr_pkg::av_data_t lo;
    ts_csr_pkg::av_data_t hi;
    av_read(ts_csr_pkg::REG_EVT_LO, lo);
    av_read(ts_csr_pkg::REG_EVT_HI, hi);
    ev.halves.lo = lo;
    ev.halves.hi = hi;
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic report_field(input string name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("FAIL %s.%s: expected 0x%0h, got 0x%0h", name, field, exp, act);
  endtask

  task automatic check_data(input string name, input ts_csr_pkg::av_data_t exp,
                            input ts_csr_pkg::av_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected 0x%04h, got 0x%04h", name, exp, act);
    end
  endtask

  task automatic check_event(input string name, input ts_stream_pkg::pid_event_u exp,
                             input ts_stream_pkg::pid_event_u act);
    checks++;
    if (act.fields.zero !== exp.fields.zero)
      report_field(name, "zero", 32'(exp.fields.zero), 32'(act.fields.zero));
    if (act.fields.key.port !== exp.fields.key.port)
      report_field(name, "port", 32'(exp.fields.key.port), 32'(act.fields.key.port));
    if (act.fields.key.pid !== exp.fields.key.pid)
      report_field(name, "pid", 32'(exp.fields.key.pid), 32'(act.fields.key.pid));
    if (act.fields.run !== exp.fields.run)
      report_field(name, "run", 32'(exp.fields.run), 32'(act.fields.run));
  endtask

  task automatic check_elapsed(input string name, input logic [27:0] lo_bound,
                               input logic [27:0] hi_bound, input logic [27:0] act);
    checks++;
    if ((act < lo_bound) || (act > hi_bound)) begin
      errors++;
      $display("FAIL %s: 0x%07h outside 0x%07h..0x%07h", name, act, lo_bound, hi_bound);
    end
  endtask

  task automatic wait_event_count(input int target);
    ts_csr_pkg::av_data_t n;
    int                   polls;
    polls = 0;
    checks++;
    do begin
      av_read(ts_csr_pkg::REG_EVT_COUNT, n);
      polls++;
    end while ((n != ts_csr_pkg::av_data_t'(target)) && (polls < POLL_LIMIT));
    if (n != ts_csr_pkg::av_data_t'(target)) begin
      errors++;
      $display("Event count stuck at %0d, never reached %0d", n, target);
    end
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic reset_defaults();
    ts_csr_pkg::av_data_t v;
    port_t                p;
    av_read(ts_csr_pkg::REG_EVT_COUNT, v);
    check_data("evt_count", '0, v);
    for (int i = 0; i < 8; i++) begin
      p = random_port();
      read_rate(p, v);
      check_data($sformatf("rate[%0d]", p), '0, v);
    end
  endtask

  task automatic rate_count_and_clear();
    port_t                ports [6];
    int                   model [6];
    int                   k;
    port_t                base;
    ts_csr_pkg::av_data_t v;
    base = random_port();
    for (int i = 0; i < 6; i++) begin
      ports[i] = base + port_t'(i * 37);
      model[i] = 0;
    end
    for (int n = 0; n < RATE_PKTS; n++) begin
      k = int'(next_random() >> 16) % 6;
      send_packet(ports[k], random_pid());
      model[k]++;
    end
    repeat (4) @(negedge avalon_clk);
    for (int i = 0; i < 6; i++) begin
      read_rate(ports[i], v);
      check_data($sformatf("rate[%0d]", ports[i]), ts_csr_pkg::av_data_t'(model[i]), v);
    end
    // Clear one entry, the rest keep their counts
    av_write(ts_csr_pkg::REG_RATE_PORT, ts_csr_pkg::av_data_t'(ports[0]));
    av_write(ts_csr_pkg::REG_RATE, '0);
    model[0] = 0;
    av_read(ts_csr_pkg::REG_RATE_PORT, v);
    check_data("rate_port", ts_csr_pkg::av_data_t'(ports[0]), v);
    for (int i = 0; i < 6; i++) begin
      read_rate(ports[i], v);
      check_data($sformatf("rate[%0d]", ports[i]), ts_csr_pkg::av_data_t'(model[i]), v);
    end
  endtask

  task automatic pid_run_events();
    port_t                     sel;
    port_t                     other;
    pid_t                      pa;
    ts_stream_pkg::pid_event_u ev;
    ts_csr_pkg::av_data_t      v;
    sel   = random_port();
    other = sel ^ 9'h0a5;
    pa    = random_pid();
    select_port(sel);
    av_read(ts_csr_pkg::REG_SEL_PORT, v);
    check_data("sel_port", ts_csr_pkg::av_data_t'(sel), v);
    send_packet(sel, pa);
    send_packet(other, pa);
    send_packet(sel, pa);
    send_packet(other, pa + 13'd1);
    send_packet(sel, pa);
    send_packet(sel, pa + 13'd1);
    send_packet(other, pa + 13'd2);
    send_packet(sel, pa + 13'd1);
    send_packet(sel, pa + 13'd2);
    wait_event_count(2);
    read_event(ev);
    check_event("run_a", make_event(sel, pa, 8'd3), ev);
    read_event(ev);
    check_event("run_b", make_event(sel, pa + 13'd1, 8'd2), ev);
    av_read(ts_csr_pkg::REG_EVT_LO, v);
    check_data("evt_lo_empty", '0, v);
  endtask

  task automatic saturated_run();
    port_t                     sel;
    pid_t                      pk;
    ts_stream_pkg::pid_event_u ev;
    sel = random_port();
    pk  = random_pid();
    select_port(sel);
    repeat (SAT_PKTS) send_packet(sel, pk);
    send_packet(sel, pk + 13'd5);
    wait_event_count(2);
    read_event(ev);
    check_event("sat_full", make_event(sel, pk, 8'd255), ev);
    read_event(ev);
    check_event("sat_rest", make_event(sel, pk, 8'(SAT_PKTS - 255)), ev);
  endtask

  task automatic select_flush();
    port_t                     sel;
    pid_t                      pa;
    ts_stream_pkg::pid_event_u ev;
    ts_csr_pkg::av_data_t      v;
    sel = random_port();
    pa  = random_pid();
    select_port(sel);
    send_packet(sel, pa);
    send_packet(sel, pa);
    send_packet(sel, pa + 13'd1);
    wait_event_count(1);
    select_port(sel);
    av_read(ts_csr_pkg::REG_EVT_COUNT, v);
    check_data("evt_count_flushed", '0, v);
    // History is gone, so the first packet of the new run is silent
    send_packet(sel, pa + 13'd2);
    repeat (8) @(negedge avalon_clk);
    av_read(ts_csr_pkg::REG_EVT_COUNT, v);
    check_data("evt_count_first", '0, v);
    send_packet(sel, pa + 13'd3);
    wait_event_count(1);
    read_event(ev);
    check_event("after_flush", make_event(sel, pa + 13'd2, 8'd1), ev);
  endtask

  task automatic timer_split_read();
    ts_csr_pkg::av_data_t lo;
    ts_csr_pkg::av_data_t hi;
    logic [27:0]          t0;
    logic [27:0]          t1;
    av_read(ts_csr_pkg::REG_TIMER_LO, lo);
    av_read(ts_csr_pkg::REG_TIMER_HI, hi);
    t0 = {hi[11:0], lo};
    repeat (TIMER_K * MS_DIVIDE) @(negedge avalon_clk);
    av_read(ts_csr_pkg::REG_TIMER_LO, lo);
    av_read(ts_csr_pkg::REG_TIMER_HI, hi);
    t1 = {hi[11:0], lo};
    check_elapsed("ms_elapsed", 28'(TIMER_K - 1), 28'(TIMER_K + 1), t1 - t0);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge avalon_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    errors           = 0;
    checks           = 0;
    lcg_state        = 32'hd280;
    stream_valid     = 1'b0;
    stream_start     = 1'b0;
    stream_data      = '0;
    avalon_address   = '0;
    avalon_read      = 1'b0;
    avalon_write     = 1'b0;
    avalon_writedata = '0;
    @(negedge avalon_rst);
    // Let the rate table finish its init sweep
    repeat (N_PORTS + 8) @(negedge avalon_clk);
    reset_defaults();
    rate_count_and_clear();
    pid_run_events();
    saturated_run();
    select_flush();
    timer_split_read();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/ts_stream_pkg.sv
common/ts_csr_pkg.sv
common/evt_read_if.sv
csr/ms_timer.sv
csr/ts_csr_decode.sv
tracker/pid_run_tracker.sv
tracker/pid_event_fifo.sv
logic/port_rate_table.sv
logic/ts_input_status.sv
tests/tb_clock_gen.sv
tests/tb_ts_input_status.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f filelist.f --top-module tb_ts_input_status -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ts_input_status > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
exit 0
